// ==== include/chol_defs.svh ====
`ifndef CHOL_DEFS_SVH
`define CHOL_DEFS_SVH

// problem size
`define N_BANDS 8
`define MAX_EM 4

// number formats, samples Q8.8, words Q16.16
`define SAMPLE_W 16
`define WORD_W 32
`define FRAC_BITS 16

// derived widths
`define EM_W $clog2(`MAX_EM)
`define BAND_W $clog2(`N_BANDS)
`define TRI_DEPTH (`MAX_EM * (`MAX_EM + 1) / 2)  // lower triangle incl. diagonal

`endif

// ==== hdl/chol_types_pkg.sv ====
`default_nettype none

`include "chol_defs.svh"

package chol_types_pkg;

  // signed Q8.8 band sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // signed Q16.16 stored value
  typedef logic signed [`WORD_W-1:0] word_t;

  // full product of two words before rescaling
  typedef logic signed [2*`WORD_W-1:0] wide_t;

  // row solver phases
  typedef enum logic [1:0] {
    IDLE,    // idle or waiting on the gram column
    DOT,     // operand reads and dot product
    DIVIDE,  // off-diagonal quotient
    ROOT     // diagonal square root
  } solve_phase_t;

endpackage

`default_nettype wire

// ==== hdl/chol_mem_pkg.sv ====
`default_nettype none

`include "chol_defs.svh"

package chol_mem_pkg;

  // row or column of L
  typedef logic [`EM_W-1:0] em_idx_t;

  // packed lower triangle address, row*(row+1)/2 + col
  typedef logic [$clog2(`TRI_DEPTH)-1:0] tri_addr_t;

  // store peers, in priority order
  typedef enum logic [1:0] {
    SOLVER,
    GRAM,
    READOUT
  } req_id_t;

endpackage

`default_nettype wire

// ==== hdl/fixed_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_defs.svh"

module fixed_divider (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  div_start,
  input  chol_types_pkg::word_t div_n,
  input  chol_types_pkg::word_t div_d,
  output logic                  div_busy,
  output logic                  div_done,
  output chol_types_pkg::word_t div_q
);

  localparam int STEPS = `WORD_W + `FRAC_BITS;
  localparam int CNT_W = $clog2(STEPS);
  localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(STEPS - 1);

  logic [STEPS-1:0]   acc;  // dividend bits leave the top, quotient bits enter below
  logic [STEPS-1:0]   acc_in;
  logic [STEPS-1:0]   acc_next;
  logic [`WORD_W-1:0] den;
  logic [`WORD_W-1:0] den_in;
  logic [`WORD_W-1:0] rem;
  logic [`WORD_W-1:0] rem_in;
  logic [`WORD_W:0]   rem_sh;
  logic [`WORD_W:0]   trial;
  logic [CNT_W-1:0]   cnt;
  logic               neg;
  logic               load;

  function automatic logic [`WORD_W-1:0] mag(chol_types_pkg::word_t v);
    return v[`WORD_W-1] ? -v : v;
  endfunction

  assign load = div_start && !div_busy;

  // first quotient bit is taken in the start cycle
  always_comb begin
    if (load) begin
      acc_in = {mag(div_n), {`FRAC_BITS{1'b0}}};
      den_in = mag(div_d);
      rem_in = '0;
    end else begin
      acc_in = acc;
      den_in = den;
      rem_in = rem;
    end
    rem_sh   = {rem_in, acc_in[STEPS-1]};
    trial    = rem_sh - {1'b0, den_in};
    acc_next = {acc_in[STEPS-2:0], ~trial[`WORD_W]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      div_busy <= 1'b0;
      div_done <= 1'b0;
      cnt      <= '0;
    end else begin
      div_done <= 1'b0;
      if (load || div_busy) begin
        acc <= acc_next;
        den <= den_in;
        rem <= trial[`WORD_W] ? rem_sh[`WORD_W-1:0] : trial[`WORD_W-1:0];  // restore
      end
      if (load) begin
        div_busy <= 1'b1;
        cnt      <= CNT_INIT;
        neg      <= div_n[`WORD_W-1] ^ div_d[`WORD_W-1];
      end else if (div_busy && cnt == CNT_W'(1)) begin
        div_busy <= 1'b0;
        div_done <= 1'b1;
        div_q    <= neg ? -acc_next[`WORD_W-1:0] : acc_next[`WORD_W-1:0];
      end else if (div_busy) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fixed_sqrt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_defs.svh"

module fixed_sqrt (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sqrt_start,
  input  chol_types_pkg::word_t sqrt_n,
  output logic                  sqrt_busy,
  output logic                  sqrt_done,
  output chol_types_pkg::word_t sqrt_root
);

  localparam int RAD_W  = `WORD_W + `FRAC_BITS;  // radicand scaled by 2^FRAC_BITS
  localparam int ROOT_W = RAD_W / 2;
  localparam int REM_W  = ROOT_W + 2;
  localparam int CNT_W  = $clog2(ROOT_W);
  localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(ROOT_W - 1);

  logic [RAD_W-1:0]  rad;
  logic [RAD_W-1:0]  rad_in;
  logic [ROOT_W-1:0] root;
  logic [ROOT_W-1:0] root_in;
  logic [ROOT_W-1:0] root_next;
  logic [REM_W-1:0]  rem;
  logic [REM_W-1:0]  rem_in;
  logic [REM_W-1:0]  rem_sh;
  logic [REM_W:0]    trial;
  logic [CNT_W-1:0]  cnt;
  logic              load;

  assign load = sqrt_start && !sqrt_busy;

  always_comb begin
    if (load) begin
      rad_in  = sqrt_n[`WORD_W-1] ? '0 : {sqrt_n, {`FRAC_BITS{1'b0}}};  // negative as zero
      root_in = '0;
      rem_in  = '0;
    end else begin
      rad_in  = rad;
      root_in = root;
      rem_in  = rem;
    end
    // bring down two radicand bits, try root digit 1
    rem_sh    = {rem_in[REM_W-3:0], rad_in[RAD_W-1 -: 2]};
    trial     = {1'b0, rem_sh} - {1'b0, root_in, 2'b01};
    root_next = {root_in[ROOT_W-2:0], ~trial[REM_W]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sqrt_busy <= 1'b0;
      sqrt_done <= 1'b0;
      cnt       <= '0;
    end else begin
      sqrt_done <= 1'b0;
      if (load || sqrt_busy) begin
        rad  <= rad_in << 2;
        root <= root_next;
        rem  <= trial[REM_W] ? rem_sh : trial[REM_W-1:0];
      end
      if (load) begin
        sqrt_busy <= 1'b1;
        cnt       <= CNT_INIT;
      end else if (sqrt_busy && cnt == CNT_W'(1)) begin
        sqrt_busy <= 1'b0;
        sqrt_done <= 1'b1;
        sqrt_root <= {{(`WORD_W - ROOT_W){1'b0}}, root_next};
      end else if (sqrt_busy) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tri_store_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_defs.svh"

module tri_store_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sol_req,
  input  logic                  sol_we,
  input  logic                  sol_gram,
  input  chol_mem_pkg::em_idx_t sol_row,
  input  chol_mem_pkg::em_idx_t sol_col,
  input  chol_types_pkg::word_t sol_wdata,
  input  logic                  gram_wr,
  input  chol_mem_pkg::em_idx_t gram_j,
  input  chol_types_pkg::word_t gram_data,
  input  logic                  rd_req,
  input  chol_mem_pkg::em_idx_t rd_row,
  input  chol_mem_pkg::em_idx_t rd_col,
  output logic                  sol_gnt,
  output chol_types_pkg::word_t rd_word,
  output chol_types_pkg::word_t rd_data,
  output logic                  rd_valid
);

  chol_types_pkg::word_t   l_mem [`TRI_DEPTH];
  chol_types_pkg::word_t   gram_col [`MAX_EM];  // G[j][k] of the current run
  chol_types_pkg::word_t   rdata_q;
  chol_mem_pkg::req_id_t   win;
  chol_mem_pkg::tri_addr_t addr;
  logic                    rd_gnt;

  // upper-triangle requests map onto the stored lower triangle
  function automatic chol_mem_pkg::tri_addr_t fold_addr(chol_mem_pkg::em_idx_t r,
                                                        chol_mem_pkg::em_idx_t c);
    chol_mem_pkg::em_idx_t hi;
    chol_mem_pkg::em_idx_t lo;
    hi = (r >= c) ? r : c;
    lo = (r >= c) ? c : r;
    return chol_mem_pkg::tri_addr_t'((hi * (hi + 1)) / 2 + lo);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // fixed priority, solver > gram > readout
  always_comb begin
    if (sol_req) win = chol_mem_pkg::SOLVER;
    else if (gram_wr) win = chol_mem_pkg::GRAM;
    else win = chol_mem_pkg::READOUT;
  end

  assign sol_gnt = (win == chol_mem_pkg::SOLVER);
  assign rd_gnt  = (win == chol_mem_pkg::READOUT) && rd_req && !rd_valid;  // one in flight
  assign addr    = sol_gnt ? fold_addr(sol_row, sol_col) : fold_addr(rd_row, rd_col);

  // single registered read port shared by solver and readout
  assign rd_word = rdata_q;
  assign rd_data = rdata_q;

  always_ff @(posedge clk) begin
    if (sol_gnt && sol_we && !sol_gram) l_mem[addr] <= sol_wdata;
    if (gram_wr) gram_col[gram_j] <= gram_data;
    rdata_q <= (sol_gnt && sol_gram) ? gram_col[sol_col] : l_mem[addr];
  end

  always_ff @(posedge clk) begin
    if (rst) rd_valid <= 1'b0;
    else rd_valid <= rd_gnt;
  end

endmodule

`default_nettype wire

// ==== hdl/gram_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_defs.svh"

module gram_accumulator (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  chol_mem_pkg::em_idx_t   row_k,
  input  chol_types_pkg::sample_t u_sample,
  input  chol_types_pkg::sample_t vec_sample,
  input  logic                    sample_valid,
  output logic                    band_req,
  output chol_mem_pkg::em_idx_t   band_col,
  output logic [`BAND_W-1:0]      band_idx,
  output logic                    gram_wr,
  output chol_mem_pkg::em_idx_t   gram_j,
  output chol_types_pkg::word_t   gram_data,
  output logic                    gram_done
);

  localparam logic [`BAND_W-1:0] LAST_BAND = `BAND_W'(`N_BANDS - 1);

  chol_mem_pkg::em_idx_t k_r;
  chol_mem_pkg::em_idx_t rx_col;
  chol_mem_pkg::em_idx_t prod_col;
  logic [`BAND_W-1:0]    rx_band;
  logic                  prod_v;
  logic                  prod_last;
  chol_types_pkg::word_t prod_r;
  chol_types_pkg::word_t acc;
  chol_types_pkg::word_t sum_next;

  assign sum_next = acc + prod_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      band_req  <= 1'b0;
      band_col  <= '0;
      band_idx  <= '0;
      k_r       <= '0;
      rx_col    <= '0;
      rx_band   <= '0;
      prod_v    <= 1'b0;
      prod_last <= 1'b0;
      gram_wr   <= 1'b0;
      gram_j    <= '0;
      gram_done <= 1'b0;
    end else begin
      //////////////////////////////////////////////////////////////////////
      // request stream, column-major
      if (start) begin
        band_req <= 1'b1;
        band_col <= '0;
        band_idx <= '0;
        k_r      <= row_k;
      end else if (band_req) begin
        if (band_idx == LAST_BAND) begin
          band_idx <= '0;
          if (band_col == k_r) band_req <= 1'b0;
          else band_col <= band_col + 1'b1;
        end else begin
          band_idx <= band_idx + 1'b1;
        end
      end

      //////////////////////////////////////////////////////////////////////
      // returning samples, one product stage then accumulate
      prod_v <= sample_valid;
      if (start) begin
        rx_band <= '0;
        rx_col  <= '0;
        acc     <= '0;
      end else if (sample_valid) begin
        prod_r    <= u_sample * vec_sample;  // Q8.8 x Q8.8 is exact Q16.16
        prod_col  <= rx_col;
        prod_last <= (rx_band == LAST_BAND);
        if (rx_band == LAST_BAND) begin
          rx_band <= '0;
          rx_col  <= rx_col + 1'b1;
        end else begin
          rx_band <= rx_band + 1'b1;
        end
      end

      if (prod_v && !start) acc <= prod_last ? '0 : sum_next;  // clear at column end
      gram_wr <= prod_v && prod_last;
      if (prod_v && prod_last) begin
        gram_j    <= prod_col;
        gram_data <= sum_next;
      end
      gram_done <= gram_wr && (gram_j == k_r);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/row_solver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_defs.svh"

module row_solver (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  chol_mem_pkg::em_idx_t row_k,
  input  logic                  gram_done,
  input  logic                  sol_gnt,
  input  chol_types_pkg::word_t rd_word,
  input  logic                  div_done,
  input  chol_types_pkg::word_t div_q,
  input  logic                  div_busy,
  input  logic                  sqrt_done,
  input  chol_types_pkg::word_t sqrt_root,
  input  logic                  sqrt_busy,
  output logic                  busy,
  output logic                  done,
  output logic                  sol_req,
  output logic                  sol_we,
  output logic                  sol_gram,
  output chol_mem_pkg::em_idx_t sol_row,
  output chol_mem_pkg::em_idx_t sol_col,
  output chol_types_pkg::word_t sol_wdata,
  output logic                  div_start,
  output chol_types_pkg::word_t div_n,
  output chol_types_pkg::word_t div_d,
  output logic                  sqrt_start,
  output chol_types_pkg::word_t sqrt_n
);

  // operand reads within DOT
  typedef enum logic [1:0] {
    OP_GRAM,  // G[j][k]
    OP_LJ,    // L[j][m]
    OP_LK,    // L[k][m]
    OP_DIAG   // L[j][j]
  } dot_op_t;

  chol_types_pkg::solve_phase_t phase;
  dot_op_t                      op;
  chol_mem_pkg::em_idx_t        k_r;
  chol_mem_pkg::em_idx_t        j_r;
  chol_mem_pkg::em_idx_t        m_r;
  logic                         pend;   // read granted, data next cycle
  logic                         wr_on;  // result write pending
  logic                         go_r;   // unit launch pending
  logic                         dot_last;
  chol_types_pkg::word_t        g_r;
  chol_types_pkg::word_t        sum_r;
  chol_types_pkg::word_t        a_r;
  chol_types_pkg::word_t        d_r;
  chol_types_pkg::word_t        res_r;
  chol_types_pkg::word_t        diff;
  chol_types_pkg::wide_t        prod;

  assign prod = chol_types_pkg::wide_t'(a_r) * chol_types_pkg::wide_t'(rd_word);
  assign diff = g_r - sum_r;

  assign div_n     = diff;
  assign div_d     = d_r;
  assign sqrt_n    = diff;
  assign sol_wdata = res_r;
  assign div_start  = go_r && (phase == chol_types_pkg::DIVIDE) && !div_busy;
  assign sqrt_start = go_r && (phase == chol_types_pkg::ROOT) && !sqrt_busy;

  assign sol_req  = wr_on || ((phase == chol_types_pkg::DOT) && !pend);
  assign sol_we   = wr_on;
  assign sol_gram = (phase == chol_types_pkg::DOT) && (op == OP_GRAM);

  // last term of the dot product for column j
  assign dot_last = (op == OP_GRAM) ? (j_r == '0)
                                    : (chol_mem_pkg::em_idx_t'(m_r + 1'b1) == j_r);

  always_comb begin
    sol_row = k_r;  // result write and gram entry
    sol_col = j_r;
    if (!wr_on) begin
      case (op)
        OP_LJ: begin
          sol_row = j_r;
          sol_col = m_r;
        end
        OP_LK:   sol_col = m_r;
        OP_DIAG: sol_row = j_r;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= chol_types_pkg::IDLE;
      op    <= OP_GRAM;
      busy  <= 1'b0;
      done  <= 1'b0;
      pend  <= 1'b0;
      wr_on <= 1'b0;
      go_r  <= 1'b0;
      k_r   <= '0;
      j_r   <= '0;
      m_r   <= '0;
    end else begin
      done <= 1'b0;
      case (phase)
        chol_types_pkg::IDLE: begin
          if (done) begin
            busy <= 1'b0;
          end else if (!busy && start) begin
            busy <= 1'b1;
            k_r  <= row_k;
          end else if (busy && gram_done) begin
            phase <= chol_types_pkg::DOT;
            op    <= OP_GRAM;
            j_r   <= '0;
            m_r   <= '0;
            sum_r <= '0;
          end
        end

        chol_types_pkg::DOT: begin
          if (!pend) begin
            pend <= sol_gnt;
          end else begin
            pend <= 1'b0;
            case (op)
              OP_LJ: begin
                a_r <= rd_word;
                op  <= OP_LK;
              end
              OP_DIAG: begin
                d_r   <= rd_word;
                phase <= chol_types_pkg::DIVIDE;
                go_r  <= 1'b1;
              end
              default: begin
                if (op == OP_GRAM) g_r <= rd_word;
                else sum_r <= sum_r + chol_types_pkg::word_t'(prod >>> `FRAC_BITS);
                if (!dot_last) begin
                  if (op == OP_LK) m_r <= m_r + 1'b1;
                  op <= OP_LJ;
                end else if (j_r == k_r) begin
                  phase <= chol_types_pkg::ROOT;
                  go_r  <= 1'b1;
                end else begin
                  op <= OP_DIAG;
                end
              end
            endcase
          end
        end

        default: begin  // DIVIDE or ROOT
          if (div_start || sqrt_start) go_r <= 1'b0;
          if (div_done || sqrt_done) begin
            res_r <= (phase == chol_types_pkg::DIVIDE) ? div_q : sqrt_root;
            wr_on <= 1'b1;
          end
          if (wr_on && sol_gnt) begin
            wr_on <= 1'b0;
            if (phase == chol_types_pkg::ROOT) begin
              phase <= chol_types_pkg::IDLE;
              done  <= 1'b1;
            end else begin
              phase <= chol_types_pkg::DOT;  // next column
              op    <= OP_GRAM;
              j_r   <= j_r + 1'b1;
              m_r   <= '0;
              sum_r <= '0;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/chol_update_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_defs.svh"

module chol_update_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  chol_mem_pkg::em_idx_t   row_k,
  input  chol_types_pkg::sample_t u_sample,
  input  chol_types_pkg::sample_t vec_sample,
  input  logic                    sample_valid,
  input  logic                    rd_req,
  input  chol_mem_pkg::em_idx_t   rd_row,
  input  chol_mem_pkg::em_idx_t   rd_col,
  output logic                    band_req,
  output chol_mem_pkg::em_idx_t   band_col,
  output logic [`BAND_W-1:0]      band_idx,
  output chol_types_pkg::word_t   rd_data,
  output logic                    rd_valid,
  output logic                    busy,
  output logic                    done
);

  logic                  run_start;
  logic                  gram_wr;
  logic                  gram_done;
  chol_mem_pkg::em_idx_t gram_j;
  chol_types_pkg::word_t gram_data;
  logic                  sol_req;
  logic                  sol_we;
  logic                  sol_gram;
  logic                  sol_gnt;
  chol_mem_pkg::em_idx_t sol_row;
  chol_mem_pkg::em_idx_t sol_col;
  chol_types_pkg::word_t sol_wdata;
  chol_types_pkg::word_t rd_word;
  logic                  div_start;
  logic                  div_busy;
  logic                  div_done;
  chol_types_pkg::word_t div_n;
  chol_types_pkg::word_t div_d;
  chol_types_pkg::word_t div_q;
  logic                  sqrt_start;
  logic                  sqrt_busy;
  logic                  sqrt_done;
  chol_types_pkg::word_t sqrt_n;
  chol_types_pkg::word_t sqrt_root;

  assign run_start = start && !busy;  // one run at a time

  gram_accumulator u_gram (.start(run_start), .*);

  row_solver u_solver (.start(run_start), .*);

  tri_store_arbiter u_store (.*);

  fixed_divider u_div (.*);

  fixed_sqrt u_sqrt (.*);

endmodule

`default_nettype wire

// ==== test/chol_update_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module chol_update_sva (
  input logic clk,
  input logic rst,
  input logic done,
  input logic sol_req,
  input logic sol_gnt,
  input logic div_start,
  input logic div_busy,
  input logic sqrt_start,
  input logic sqrt_busy,
  input logic rd_req,
  input logic rd_valid
);

  int fail_cnt = 0;  // polled by the testbench

  done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done held for more than one cycle");
      fail_cnt++;
    end

  // a solver grant leaves no slot for readout, so no read data next cycle
  gnt_blocks_read: assert property (@(posedge clk) disable iff (rst)
                                    (sol_gnt && sol_req) |=> !rd_valid)
    else begin
      $error("readout served in a cycle granted to the solver");
      fail_cnt++;
    end

  div_idle_start: assert property (@(posedge clk) disable iff (rst)
                                   (div_start && !div_busy) |=> div_busy)
    else begin
      $error("divider start from idle was not taken");
      fail_cnt++;
    end

  sqrt_idle_start: assert property (@(posedge clk) disable iff (rst)
                                    (sqrt_start && !sqrt_busy) |=> sqrt_busy)
    else begin
      $error("sqrt start from idle was not taken");
      fail_cnt++;
    end

  valid_with_req: assert property (@(posedge clk) disable iff (rst) rd_valid |-> rd_req)
    else begin
      $error("rd_valid without rd_req");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== test/chol_update_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "chol_defs.svh"

module chol_update_tb;

  localparam int DONE_LIMIT = 4000;  // cycles per run
  localparam int READ_LIMIT = 200;

  logic                    clk;
  logic                    rst;
  logic                    start;
  chol_mem_pkg::em_idx_t   row_k;
  chol_types_pkg::sample_t u_sample;
  chol_types_pkg::sample_t vec_sample;
  logic                    sample_valid;
  logic                    rd_req;
  chol_mem_pkg::em_idx_t   rd_row;
  chol_mem_pkg::em_idx_t   rd_col;
  logic                    band_req;
  chol_mem_pkg::em_idx_t   band_col;
  logic [`BAND_W-1:0]      band_idx;
  chol_types_pkg::word_t   rd_data;
  logic                    rd_valid;
  logic                    busy;
  logic                    done;

  chol_types_pkg::sample_t u_mem [`N_BANDS][`MAX_EM];
  chol_types_pkg::word_t   ref_g [`MAX_EM][`MAX_EM];
  chol_types_pkg::word_t   ref_l [`MAX_EM][`MAX_EM];
  chol_types_pkg::word_t   exp_q [$];  // expected readouts in flight
  logic [31:0]             lfsr_state;
  int                      cur_k;
  int                      req_cnt = 0;
  int                      done_cnt = 0;
  logic                    done_prev;
  logic                    pend_v;
  chol_mem_pkg::em_idx_t   pend_c;
  logic [`BAND_W-1:0]      pend_b;

  chol_update_top uut (.*);

  bind chol_update_top chol_update_sva u_sva (
    .clk(clk), .rst(rst), .done(done),
    .sol_req(sol_req), .sol_gnt(sol_gnt),
    .div_start(div_start), .div_busy(div_busy),
    .sqrt_start(sqrt_start), .sqrt_busy(sqrt_busy),
    .rd_req(rd_req), .rd_valid(rd_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus source and reference model

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic void fill_u();
    logic [7:0] r;
    for (int b = 0; b < `N_BANDS; b++) begin
      for (int c = 0; c < `MAX_EM; c++) begin
        r = take_bits(8);
        u_mem[b][c] = {{8{r[7]}}, r};  // within +-0.5
        if (b == c) u_mem[b][c] = u_mem[b][c] + 16'sh0400;  // strong diagonal
      end
    end
  endfunction

  function automatic chol_types_pkg::word_t mul_fix(input chol_types_pkg::word_t a,
                                                    input chol_types_pkg::word_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return chol_types_pkg::word_t'(p >>> `FRAC_BITS);
  endfunction

  function automatic chol_types_pkg::word_t div_fix(input chol_types_pkg::word_t n,
                                                    input chol_types_pkg::word_t d);
    longint q;
    q = (longint'(n) * (longint'(1) << `FRAC_BITS)) / longint'(d);  // truncates to zero
    return chol_types_pkg::word_t'(q);
  endfunction

  function automatic chol_types_pkg::word_t sqrt_fix(input chol_types_pkg::word_t n);
    longint x;
    longint lo;
    longint hi;
    longint mid;
    if (n < 0) return '0;
    x  = longint'(n) << `FRAC_BITS;
    lo = 0;
    hi = longint'(1) << ((`WORD_W + `FRAC_BITS) / 2);
    while (lo < hi) begin  // largest lo with lo*lo <= x
      mid = (lo + hi + 1) / 2;
      if (mid * mid <= x) lo = mid;
      else hi = mid - 1;
    end
    return chol_types_pkg::word_t'(lo);
  endfunction

  function automatic void build_reference();
    chol_types_pkg::word_t s;
    for (int k = 0; k < `MAX_EM; k++) begin
      for (int j = 0; j <= k; j++) begin
        ref_g[j][k] = '0;
        for (int b = 0; b < `N_BANDS; b++)
          ref_g[j][k] += chol_types_pkg::word_t'(u_mem[b][j]) *
                         chol_types_pkg::word_t'(u_mem[b][k]);
      end
      for (int j = 0; j < k; j++) begin
        s = '0;
        for (int m = 0; m < j; m++) s += mul_fix(ref_l[j][m], ref_l[k][m]);
        ref_l[k][j] = div_fix(ref_g[j][k] - s, ref_l[j][j]);
      end
      s = '0;
      for (int m = 0; m < k; m++) s += mul_fix(ref_l[k][m], ref_l[k][m]);
      ref_l[k][k] = sqrt_fix(ref_g[k][k] - s);
    end
  endfunction

  function automatic chol_types_pkg::word_t expected_word(input int r, input int c);
    return (r >= c) ? ref_l[r][c] : ref_l[c][r];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // failure reporting and sequencing helpers

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic step_clock();
    @(posedge clk);
    #2;
  endtask

  task automatic read_and_check(input int r, input int c);
    int n;
    exp_q.push_back(expected_word(r, c));
    rd_row = chol_mem_pkg::em_idx_t'(r);
    rd_col = chol_mem_pkg::em_idx_t'(c);
    rd_req = 1'b1;
    n = 0;
    step_clock();
    while (!rd_valid && n < READ_LIMIT) begin
      step_clock();
      n++;
    end
    if (!rd_valid) abort_run($sformatf("read of (%0d,%0d) never got rd_valid", r, c));
    step_clock();  // request stays up through the valid cycle
    rd_req = 1'b0;
  endtask

  task automatic wait_for_done(input int old_cnt);
    int n;
    n = 0;
    while (done_cnt == old_cnt && n < DONE_LIMIT) begin
      step_clock();
      n++;
    end
    if (done_cnt == old_cnt) abort_run("run never finished, no done pulse seen");
  endtask

  task automatic run_row(input int k);
    int old_cnt;
    int passes;
    cur_k   = k;
    req_cnt = 0;
    old_cnt = done_cnt;
    row_k   = chol_mem_pkg::em_idx_t'(k);
    start   = 1'b1;
    step_clock();
    start = 1'b0;
    if (k == `MAX_EM - 1) begin  // extra start mid-run, must be dropped
      step_clock();
      step_clock();
      check_value("busy", busy, 1);
      row_k = '0;
      start = 1'b1;
      step_clock();
      start = 1'b0;
    end
    passes = 0;
    while (busy && k > 0 && passes < 50) begin  // readout of earlier rows under load
      for (int r = 0; r < k; r++)
        for (int c = 0; c <= r; c++)
          if (busy) read_and_check(r, c);
      passes++;
    end
    wait_for_done(old_cnt);
    check_value("band request count", req_cnt, (k + 1) * `N_BANDS);
  endtask

  //////////////////////////////////////////////////////////////////////
  // processes

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // band samples, one cycle after each request
  initial begin
    sample_valid = 1'b0;
    u_sample     = '0;
    vec_sample   = '0;
    pend_v       = 1'b0;
    forever begin
      step_clock();
      sample_valid = pend_v;
      u_sample     = pend_v ? u_mem[pend_b][pend_c] : '0;
      vec_sample   = pend_v ? u_mem[pend_b][cur_k] : '0;
      pend_v       = band_req;
      pend_c       = band_col;
      pend_b       = band_idx;
    end
  end

  // compares at the falling edge, outputs settled
  initial begin
    done_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (uut.u_sva.fail_cnt != 0) abort_run("a bound assertion failed");
        if (band_req) begin
          check_value("band_col", band_col, req_cnt / `N_BANDS);
          check_value("band_idx", band_idx, req_cnt % `N_BANDS);
          req_cnt++;
        end
        if (done_prev) begin
          check_value("done", done, 0);
          check_value("busy", busy, 0);
        end
        if (done) begin
          check_value("busy", busy, 1);
          done_cnt++;
        end
        done_prev = done;
        if (rd_valid) begin
          if (exp_q.size() == 0) abort_run("rd_valid seen with no read outstanding");
          else check_value("rd_data", rd_data, exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    rst    = 1'b1;
    start  = 1'b0;
    row_k  = '0;
    rd_req = 1'b0;
    rd_row = '0;
    rd_col = '0;
    cur_k  = 0;
    lfsr_state = 32'h28b0_34e0;
    fill_u();
    build_reference();
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    repeat (3) begin
      step_clock();
      check_value("busy", busy, 0);
      check_value("done", done, 0);
      check_value("band_req", band_req, 0);
      check_value("rd_valid", rd_valid, 0);
    end
    for (int k = 0; k < `MAX_EM; k++) run_row(k);
    // whole triangle, both orientations
    for (int r = 0; r < `MAX_EM; r++)
      for (int c = 0; c < `MAX_EM; c++)
        read_and_check(r, c);
    step_clock();
    step_clock();
    if (uut.u_sva.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
hdl/chol_types_pkg.sv
hdl/chol_mem_pkg.sv
hdl/fixed_divider.sv
hdl/fixed_sqrt.sv
hdl/tri_store_arbiter.sv
hdl/gram_accumulator.sv
hdl/row_solver.sv
hdl/chol_update_top.sv
test/chol_update_sva.sv
test/chol_update_tb.sv
